/* logic/sbn_egress.sv */
`timescale 1ns/1ns
`default_nettype none

module sbn_egress #(
  parameter int QUEUE_DEPTH = 4,
  parameter int MY_PORT     = 0
) (
  input  logic                                                  side_clk,
  input  logic                                                  rst_n,
  input  logic [sbn_topo_pkg::ROUTER_PORTS-1:0]                 req_valid,
  input  sbn_topo_pkg::lport_t [sbn_topo_pkg::ROUTER_PORTS-1:0]  req_dest,
  input  sbn_msg_pkg::payload_t [sbn_topo_pkg::ROUTER_PORTS-1:0] req_payload,
  input  logic [sbn_topo_pkg::ROUTER_PORTS-1:0]                 req_eom,
  output logic [sbn_topo_pkg::ROUTER_PORTS-1:0]                 pop,
  output logic                                                  put,
  output sbn_msg_pkg::payload_t                                 payload,
  output logic                                                  eom,
  input  logic                                                  credit_up
);

  import sbn_msg_pkg::*;
  import sbn_topo_pkg::*;

  arb_state_t              state;
  lport_t                  owner;
  lport_t                  pick;
  logic                    pick_found;
  lport_t                  sel;
  logic                    sel_ok;
  logic                    grant;
  credit_cnt_t             cred;
  logic [ROUTER_PORTS-1:0] req_hit;

  // ----------------------------------------------------------------------
  // Request select
  // ----------------------------------------------------------------------

  always_comb
  begin
    for (int i = 0; i < ROUTER_PORTS; i++)
      req_hit[i] = req_valid[i] && (req_dest[i] == lport_t'(MY_PORT));
  end

  // Round robin from the port after the last winner
  always_comb
  begin
    pick       = owner;
    pick_found = 1'b0;
    for (int k = 1; k <= ROUTER_PORTS; k++)
    begin
      if (!pick_found && req_hit[(int'(owner) + k) % ROUTER_PORTS])
      begin
        pick       = lport_t'((int'(owner) + k) % ROUTER_PORTS);
        pick_found = 1'b1;
      end
    end
  end

  // Locked onto the owner until its eom flit goes
  assign sel    = (state == arb_locked) ? owner : pick;
  assign sel_ok = (state == arb_locked) ? req_hit[owner] : pick_found;
  assign grant  = sel_ok && (cred != '0);

  always_comb
  begin
    pop = '0;
    if (grant)
      pop[sel] = 1'b1;
  end

  always_ff @(posedge side_clk)
  begin
    if (!rst_n)
    begin
      state <= arb_idle;
      owner <= lport_t'(ROUTER_PORTS - 1);
    end
    else if (grant)
    begin
      owner <= sel;
      state <= req_eom[sel] ? arb_idle : arb_locked;
    end
  end

  // ----------------------------------------------------------------------
  // Downstream credits and output stage
  // ----------------------------------------------------------------------

  always_ff @(posedge side_clk)
  begin
    if (!rst_n)
      cred <= '0;
    else
      cred <= cred + credit_cnt_t'(credit_up) - credit_cnt_t'(grant);
  end

  always_ff @(posedge side_clk)
  begin
    if (!rst_n)
      put <= 1'b0;
    else
      put <= grant;
  end

  always_ff @(posedge side_clk)
  begin
    if (grant)
    begin
      payload <= req_payload[sel];
      eom     <= req_eom[sel];
    end
  end

endmodule

`default_nettype wire

/* logic/sbn_fabric.sv */
`timescale 1ns/1ns
`default_nettype none

module sbn_fabric #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                                                side_clk,
  input  logic                                                rst_n,
  input  logic [sbn_topo_pkg::NUM_AGENTS-1:0]                 agent_put,
  input  sbn_msg_pkg::payload_t [sbn_topo_pkg::NUM_AGENTS-1:0] agent_payload,
  input  logic [sbn_topo_pkg::NUM_AGENTS-1:0]                 agent_eom,
  output logic [sbn_topo_pkg::NUM_AGENTS-1:0]                 agent_credit,
  output logic [sbn_topo_pkg::NUM_AGENTS-1:0]                 out_put,
  output sbn_msg_pkg::payload_t [sbn_topo_pkg::NUM_AGENTS-1:0] out_payload,
  output logic [sbn_topo_pkg::NUM_AGENTS-1:0]                 out_eom,
  input  logic [sbn_topo_pkg::NUM_AGENTS-1:0]                 out_credit
);

  import sbn_msg_pkg::*;
  import sbn_topo_pkg::*;

  logic     [ROUTER_PORTS-1:0] r0_in_put;
  payload_t [ROUTER_PORTS-1:0] r0_in_payload;
  logic     [ROUTER_PORTS-1:0] r0_in_eom;
  logic     [ROUTER_PORTS-1:0] r0_in_credit;
  logic     [ROUTER_PORTS-1:0] r0_out_put;
  payload_t [ROUTER_PORTS-1:0] r0_out_payload;
  logic     [ROUTER_PORTS-1:0] r0_out_eom;
  logic     [ROUTER_PORTS-1:0] r0_out_credit;

  logic     [ROUTER_PORTS-1:0] r1_in_put;
  payload_t [ROUTER_PORTS-1:0] r1_in_payload;
  logic     [ROUTER_PORTS-1:0] r1_in_eom;
  logic     [ROUTER_PORTS-1:0] r1_in_credit;
  logic     [ROUTER_PORTS-1:0] r1_out_put;
  payload_t [ROUTER_PORTS-1:0] r1_out_payload;
  logic     [ROUTER_PORTS-1:0] r1_out_eom;
  logic     [ROUTER_PORTS-1:0] r1_out_credit;

  // ----------------------------------------------------------------------
  // Agents 0..1 on router 0, 2..3 on router 1, link ports cross-wired
  // ----------------------------------------------------------------------

  assign r0_in_put     = {r1_out_put[LINK_PORT], agent_put[LOCAL_PORTS-1:0]};
  assign r0_in_payload = {r1_out_payload[LINK_PORT], agent_payload[LOCAL_PORTS-1:0]};
  assign r0_in_eom     = {r1_out_eom[LINK_PORT], agent_eom[LOCAL_PORTS-1:0]};
  assign r0_out_credit = {r1_in_credit[LINK_PORT], out_credit[LOCAL_PORTS-1:0]};

  assign r1_in_put     = {r0_out_put[LINK_PORT], agent_put[NUM_AGENTS-1:LOCAL_PORTS]};
  assign r1_in_payload = {r0_out_payload[LINK_PORT], agent_payload[NUM_AGENTS-1:LOCAL_PORTS]};
  assign r1_in_eom     = {r0_out_eom[LINK_PORT], agent_eom[NUM_AGENTS-1:LOCAL_PORTS]};
  assign r1_out_credit = {r0_in_credit[LINK_PORT], out_credit[NUM_AGENTS-1:LOCAL_PORTS]};

  assign agent_credit = {r1_in_credit[LOCAL_PORTS-1:0], r0_in_credit[LOCAL_PORTS-1:0]};
  assign out_put      = {r1_out_put[LOCAL_PORTS-1:0], r0_out_put[LOCAL_PORTS-1:0]};
  assign out_payload  = {r1_out_payload[LOCAL_PORTS-1:0], r0_out_payload[LOCAL_PORTS-1:0]};
  assign out_eom      = {r1_out_eom[LOCAL_PORTS-1:0], r0_out_eom[LOCAL_PORTS-1:0]};

  sbn_router #(
    .QUEUE_DEPTH    (QUEUE_DEPTH),
    .ROUTER_BASE_ID (0)
  ) i_router_0 (
    .side_clk    (side_clk),
    .rst_n       (rst_n),
    .in_put      (r0_in_put),
    .in_payload  (r0_in_payload),
    .in_eom      (r0_in_eom),
    .in_credit   (r0_in_credit),
    .out_put     (r0_out_put),
    .out_payload (r0_out_payload),
    .out_eom     (r0_out_eom),
    .out_credit  (r0_out_credit)
  );

  sbn_router #(
    .QUEUE_DEPTH    (QUEUE_DEPTH),
    .ROUTER_BASE_ID (LOCAL_PORTS)
  ) i_router_1 (
    .side_clk    (side_clk),
    .rst_n       (rst_n),
    .in_put      (r1_in_put),
    .in_payload  (r1_in_payload),
    .in_eom      (r1_in_eom),
    .in_credit   (r1_in_credit),
    .out_put     (r1_out_put),
    .out_payload (r1_out_payload),
    .out_eom     (r1_out_eom),
    .out_credit  (r1_out_credit)
  );

endmodule

`default_nettype wire

/* logic/sbn_ingress.sv */
`timescale 1ns/1ns
`default_nettype none

module sbn_ingress #(
  parameter int QUEUE_DEPTH    = 4,
  parameter int ROUTER_BASE_ID = 0
) (
  input  logic                  side_clk,
  input  logic                  rst_n,
  input  logic                  put,
  input  sbn_msg_pkg::payload_t payload,
  input  logic                  eom,
  output logic                  credit_up,
  output logic                  head_valid,
  output sbn_msg_pkg::payload_t head_payload,
  output logic                  head_eom,
  output sbn_topo_pkg::lport_t  head_dest,
  input  logic                  pop
);

  import sbn_msg_pkg::*;
  import sbn_topo_pkg::*;

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

  typedef logic [PTR_W-1:0] ptr_t;

  payload_t    mem_payload [QUEUE_DEPTH];
  logic        mem_eom     [QUEUE_DEPTH];
  lport_t      mem_dest    [QUEUE_DEPTH];
  ptr_t        wr_ptr;
  ptr_t        rd_ptr;
  credit_cnt_t fill;
  credit_cnt_t rel_cnt;
  credit_cnt_t owed;
  logic        in_msg;
  lport_t      msg_dest;
  lport_t      wr_dest;
  port_id_t    hdr_id;

  function automatic ptr_t next_ptr(ptr_t p);
    next_ptr = (int'(p) == QUEUE_DEPTH - 1) ? '0 : ptr_t'(p + 1'b1);
  endfunction

  // ----------------------------------------------------------------------
  // Header tracker
  // ----------------------------------------------------------------------

  assign hdr_id = payload[PORT_ID_W-1:0];

  // Local agents map to their index, all others go out the link
  always_comb
  begin
    if (in_msg)
      wr_dest = msg_dest;
    else if (int'(hdr_id) >= ROUTER_BASE_ID && int'(hdr_id) < ROUTER_BASE_ID + LOCAL_PORTS)
      wr_dest = lport_t'(int'(hdr_id) - ROUTER_BASE_ID);
    else
      wr_dest = lport_t'(LINK_PORT);
  end

  always_ff @(posedge side_clk)
  begin
    if (!rst_n)
      in_msg <= 1'b0;
    else if (put)
      in_msg <= !eom;
  end

  always_ff @(posedge side_clk)
  begin
    if (put && !in_msg)
      msg_dest <= wr_dest;
  end

  // ----------------------------------------------------------------------
  // Flit queue
  // ----------------------------------------------------------------------

  always_ff @(posedge side_clk)
  begin
    if (put)
    begin
      mem_payload[wr_ptr] <= payload;
      mem_eom[wr_ptr]     <= eom;
      mem_dest[wr_ptr]    <= wr_dest;
    end
  end

  always_ff @(posedge side_clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end
    else
    begin
      if (put)
        wr_ptr <= next_ptr(wr_ptr);
      if (pop)
        rd_ptr <= next_ptr(rd_ptr);
      fill <= fill + credit_cnt_t'(put) - credit_cnt_t'(pop);
    end
  end

  assign head_valid   = (fill != '0);
  assign head_payload = mem_payload[rd_ptr];
  assign head_eom     = mem_eom[rd_ptr];
  assign head_dest    = mem_dest[rd_ptr];

  // Initial release plus one credit per pop, at most one pulse a cycle
  assign owed = rel_cnt + credit_cnt_t'(pop);

  always_ff @(posedge side_clk)
  begin
    if (!rst_n)
    begin
      rel_cnt   <= credit_cnt_t'(QUEUE_DEPTH);
      credit_up <= 1'b0;
    end
    else
    begin
      credit_up <= (owed != '0);
      rel_cnt   <= owed - credit_cnt_t'(owed != '0);
    end
  end

endmodule

`default_nettype wire

/* logic/sbn_msg_pkg.sv */
`default_nettype none

package sbn_msg_pkg;

  // ----------------------------------------------------------------------
  // Flit format
  // ----------------------------------------------------------------------

  localparam int PAYLOAD_W = 8;
  localparam int PORT_ID_W = 2;

  // One flit on a sideband hop
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // Destination id, low bits of the header flit
  typedef logic [PORT_ID_W-1:0] port_id_t;

  // Credits held by a sender or owed by a receiver, up to 8
  typedef logic [3:0] credit_cnt_t;

endpackage

`default_nettype wire

/* logic/sbn_router.sv */
`timescale 1ns/1ns
`default_nettype none

module sbn_router #(
  parameter int QUEUE_DEPTH    = 4,
  parameter int ROUTER_BASE_ID = 0
) (
  input  logic                                                  side_clk,
  input  logic                                                  rst_n,
  input  logic [sbn_topo_pkg::ROUTER_PORTS-1:0]                 in_put,
  input  sbn_msg_pkg::payload_t [sbn_topo_pkg::ROUTER_PORTS-1:0] in_payload,
  input  logic [sbn_topo_pkg::ROUTER_PORTS-1:0]                 in_eom,
  output logic [sbn_topo_pkg::ROUTER_PORTS-1:0]                 in_credit,
  output logic [sbn_topo_pkg::ROUTER_PORTS-1:0]                 out_put,
  output sbn_msg_pkg::payload_t [sbn_topo_pkg::ROUTER_PORTS-1:0] out_payload,
  output logic [sbn_topo_pkg::ROUTER_PORTS-1:0]                 out_eom,
  input  logic [sbn_topo_pkg::ROUTER_PORTS-1:0]                 out_credit
);

  import sbn_msg_pkg::*;
  import sbn_topo_pkg::*;

  // Ingress heads, seen by every egress
  logic     [ROUTER_PORTS-1:0] head_valid;
  payload_t [ROUTER_PORTS-1:0] head_payload;
  logic     [ROUTER_PORTS-1:0] head_eom;
  lport_t   [ROUTER_PORTS-1:0] head_dest;

  // Pops, indexed by egress then ingress
  logic [ROUTER_PORTS-1:0] pop_mat [ROUTER_PORTS];
  logic [ROUTER_PORTS-1:0] ing_pop;

  always_comb
  begin
    ing_pop = '0;
    for (int e = 0; e < ROUTER_PORTS; e++)
      ing_pop = ing_pop | pop_mat[e];
  end

  for (genvar p = 0; p < ROUTER_PORTS; p++)
  begin : gen_port
    sbn_ingress #(
      .QUEUE_DEPTH    (QUEUE_DEPTH),
      .ROUTER_BASE_ID (ROUTER_BASE_ID)
    ) i_ingress (
      .side_clk     (side_clk),
      .rst_n        (rst_n),
      .put          (in_put[p]),
      .payload      (in_payload[p]),
      .eom          (in_eom[p]),
      .credit_up    (in_credit[p]),
      .head_valid   (head_valid[p]),
      .head_payload (head_payload[p]),
      .head_eom     (head_eom[p]),
      .head_dest    (head_dest[p]),
      .pop          (ing_pop[p])
    );

    sbn_egress #(
      .QUEUE_DEPTH (QUEUE_DEPTH),
      .MY_PORT     (p)
    ) i_egress (
      .side_clk    (side_clk),
      .rst_n       (rst_n),
      .req_valid   (head_valid),
      .req_dest    (head_dest),
      .req_payload (head_payload),
      .req_eom     (head_eom),
      .pop         (pop_mat[p]),
      .put         (out_put[p]),
      .payload     (out_payload[p]),
      .eom         (out_eom[p]),
      .credit_up   (out_credit[p])
    );
  end

endmodule

`default_nettype wire

/* logic/sbn_topo_pkg.sv */
`default_nettype none

package sbn_topo_pkg;

  // ----------------------------------------------------------------------
  // Fabric topology
  // ----------------------------------------------------------------------

  localparam int NUM_AGENTS   = 4;
  localparam int LOCAL_PORTS  = 2;
  localparam int ROUTER_PORTS = LOCAL_PORTS + 1;

  // Link to the other router sits above the local ports
  localparam int LINK_PORT    = 2;

  typedef logic [1:0] lport_t;

  // Output arbiter
  typedef enum logic {
    arb_idle,
    arb_locked
  } arb_state_t;

endpackage

`default_nettype wire

/* sbn_fabric.f */
+incdir+test
logic/sbn_msg_pkg.sv
logic/sbn_topo_pkg.sv
logic/sbn_ingress.sv
logic/sbn_egress.sv
logic/sbn_router.sv
logic/sbn_fabric.sv
test/tb_sbn_fabric.sv

/* test/sbn_input.txt */
# source payload eom, all hex, one flit per line
# header low bits name the destination, second flit is the source id
0 41 0
0 00 0
0 a5 0
0 5a 1
0 c2 0
0 00 0
0 13 1
0 f1 0
0 00 0
0 e0 0
0 e1 0
0 e2 1
1 10 0
1 01 0
1 77 1
1 27 0
1 01 0
1 3c 0
1 c3 1
1 d5 0
1 01 0
1 99 1
2 63 0
2 02 0
2 4e 1
2 34 0
2 02 0
2 f0 0
2 0f 1
2 b9 0
2 02 0
2 66 0
2 67 1
3 e6 0
3 03 0
3 81 1
3 1d 0
3 03 0
3 42 1
3 a1 0
3 03 0
3 c8 0
3 c9 1

/* test/sbn_fabric_checks.svh */
`ifndef SBN_FABRIC_CHECKS_SVH
`define SBN_FABRIC_CHECKS_SVH

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------

task automatic check_payload(payload_t got, payload_t exp, string what);
  if (got !== exp)
  begin
    value_errs++;
    $display("** Error at %0t: %s payload %02h, expected %02h", $time, what, got, exp);
  end
endtask

task automatic check_eom(logic got, logic exp, string what);
  if (got !== exp)
  begin
    value_errs++;
    $display("** Error at %0t: %s eom %b, expected %b", $time, what, got, exp);
  end
endtask

task automatic check_dest(port_id_t got, port_id_t exp, string what);
  if (got !== exp)
  begin
    value_errs++;
    $display("** Error at %0t: %s names agent %0d, delivered to agent %0d",
             $time, what, got, exp);
  end
endtask

task automatic check_count(credit_cnt_t got, credit_cnt_t exp, string what);
  if (got !== exp)
  begin
    value_errs++;
    $display("** Error at %0t: %s %0d, expected %0d", $time, what, got, exp);
  end
endtask

// ----------------------------------------------------------------------
// Scoreboard
// ----------------------------------------------------------------------

// Oldest pending message with the same source and destination
task automatic match_message(int d);
  int src;
  int hdr_dest;
  int idx;
  int m;
  int len;
  int j;
  int k;
  idx = -1;
  if (rx_len[d] >= 2)
  begin
    src      = int'(rx_payload[d][1]);
    hdr_dest = int'(rx_payload[d][0][PORT_ID_W-1:0]);
    for (j = 0; j < pending.size(); j++)
      if (idx < 0 && msg_src[pending[j]] == src && msg_dest[pending[j]] == hdr_dest)
        idx = j;
  end
  if (idx < 0)
  begin
    other_errs++;
    $display("agent %0d received a message that matches nothing still expected", d);
  end
  else
  begin
    m = pending[idx];
    pending.delete(idx);
    check_dest(port_id_t'(rx_payload[d][0]), port_id_t'(d), $sformatf("message %0d header", m));
    if (rx_len[d] != msg_len[m])
    begin
      value_errs++;
      $display("** Error at %0t: message %0d length %0d, expected %0d",
               $time, m, rx_len[d], msg_len[m]);
    end
    len = (rx_len[d] < msg_len[m]) ? rx_len[d] : msg_len[m];
    for (k = 0; k < len; k++)
    begin
      check_payload(rx_payload[d][k], stim_payload[msg_flit[m][k]],
                    $sformatf("message %0d flit %0d", m, k));
      check_eom(k == rx_len[d] - 1, stim_eom[msg_flit[m][k]],
                $sformatf("message %0d flit %0d", m, k));
    end
  end
  rx_msgs++;
endtask

`endif

/* test/tb_sbn_fabric.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_sbn_fabric;

  import sbn_msg_pkg::*;
  import sbn_topo_pkg::*;

  localparam int QUEUE_DEPTH = 4;
  localparam int MAX_FLITS   = 256;
  localparam int MAX_MSGS    = 64;
  localparam int MAX_LEN     = 16;

  logic                      side_clk;
  logic                      rst_n;
  logic     [NUM_AGENTS-1:0] agent_put;
  payload_t [NUM_AGENTS-1:0] agent_payload;
  logic     [NUM_AGENTS-1:0] agent_eom;
  logic     [NUM_AGENTS-1:0] agent_credit;
  logic     [NUM_AGENTS-1:0] out_put;
  payload_t [NUM_AGENTS-1:0] out_payload;
  logic     [NUM_AGENTS-1:0] out_eom;
  logic     [NUM_AGENTS-1:0] out_credit;

  // Stimulus as read from the data file
  payload_t stim_payload [MAX_FLITS];
  logic     stim_eom     [MAX_FLITS];
  int       num_flits;
  int       num_msgs;
  int       src_flit [NUM_AGENTS][MAX_FLITS];
  int       src_cnt  [NUM_AGENTS];
  int       src_pos  [NUM_AGENTS];
  int       msg_src  [MAX_MSGS];
  int       msg_dest [MAX_MSGS];
  int       msg_len  [MAX_MSGS];
  int       msg_flit [MAX_MSGS][MAX_LEN];
  int       pending  [$];

  // Receiver state, initial release counted in credit_pulses
  payload_t    rx_payload [NUM_AGENTS][MAX_LEN];
  int          rx_len        [NUM_AGENTS];
  int          rx_flits      [NUM_AGENTS];
  int          credit_owed   [NUM_AGENTS];
  int          credit_wait   [NUM_AGENTS];
  int          credit_pulses [NUM_AGENTS];
  credit_cnt_t agent_cred    [NUM_AGENTS];
  int          rx_msgs;

  int     value_errs;
  int     other_errs;
  integer seed;
  logic   started;
  logic   loaded;

  `include "sbn_fabric_checks.svh"

  sbn_fabric #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_dut (
    .side_clk      (side_clk),
    .rst_n         (rst_n),
    .agent_put     (agent_put),
    .agent_payload (agent_payload),
    .agent_eom     (agent_eom),
    .agent_credit  (agent_credit),
    .out_put       (out_put),
    .out_payload   (out_payload),
    .out_eom       (out_eom),
    .out_credit    (out_credit)
  );

  initial
  begin
    side_clk = 1'b0;
    forever
      #5 side_clk = ~side_clk;
  end

  // Lines hold source, payload and eom in hex
  task automatic load_stimulus();
    int              fd;
    int              n;
    int              f_src;
    int              f_pl;
    int              f_eom;
    int              cur;
    int              cur_msg [NUM_AGENTS];
    logic [1023:0]   skip_buf;
    for (int a = 0; a < NUM_AGENTS; a++)
    begin
      cur_msg[a] = -1;
      src_cnt[a] = 0;
    end
    fd = $fopen("test/sbn_input.txt", "r");
    if (fd == 0)
    begin
      other_errs++;
      $display("cannot open test/sbn_input.txt");
    end
    else
    begin
      while (!$feof(fd))
      begin
        n = $fscanf(fd, "%h %h %h\n", f_src, f_pl, f_eom);
        if (n != 3)
          n = $fgets(skip_buf, fd);
        else if (f_src < 0 || f_src >= NUM_AGENTS || num_flits >= MAX_FLITS)
        begin
          other_errs++;
          $display("stimulus line with source %0d was rejected", f_src);
        end
        else
        begin
          stim_payload[num_flits] = payload_t'(f_pl);
          stim_eom[num_flits]     = f_eom[0];
          src_flit[f_src][src_cnt[f_src]] = num_flits;
          src_cnt[f_src]++;
          // First flit of a message is its header
          if (cur_msg[f_src] < 0 && num_msgs < MAX_MSGS)
          begin
            cur_msg[f_src]     = num_msgs;
            msg_src[num_msgs]  = f_src;
            msg_dest[num_msgs] = f_pl & 3;
            msg_len[num_msgs]  = 0;
            pending.push_back(num_msgs);
            num_msgs++;
          end
          cur = cur_msg[f_src];
          if (cur >= 0 && msg_len[cur] < MAX_LEN)
          begin
            msg_flit[cur][msg_len[cur]] = num_flits;
            msg_len[cur]++;
          end
          if (f_eom[0])
            cur_msg[f_src] = -1;
          num_flits++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic take_flit(int d);
    rx_flits[d]++;
    if (!started)
    begin
      other_errs++;
      $display("out_put to agent %0d before any message was sent", d);
    end
    if (rx_flits[d] > credit_pulses[d])
    begin
      other_errs++;
      $display("agent %0d got more flits than it returned credits for", d);
    end
    if (rx_len[d] < MAX_LEN)
      rx_payload[d][rx_len[d]] = out_payload[d];
    rx_len[d]++;
    if (out_eom[d] === 1'b1)
    begin
      match_message(d);
      rx_len[d] = 0;
    end
  endtask

  task automatic print_summary();
    $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
  endtask

  // ----------------------------------------------------------------------
  // Source drivers and receivers
  // ----------------------------------------------------------------------

  always @(negedge side_clk)
  begin
    for (int a = 0; a < NUM_AGENTS; a++)
    begin
      if (agent_credit[a] === 1'b1)
        agent_cred[a] = agent_cred[a] + 1'b1;
      if (agent_cred[a] > credit_cnt_t'(QUEUE_DEPTH))
      begin
        other_errs++;
        $display("agent %0d holds more credits than its ingress queue has slots", a);
        agent_cred[a] = credit_cnt_t'(QUEUE_DEPTH);
      end
      if (started && agent_cred[a] != '0 && src_pos[a] < src_cnt[a])
      begin
        agent_put[a]     = 1'b1;
        agent_payload[a] = stim_payload[src_flit[a][src_pos[a]]];
        agent_eom[a]     = stim_eom[src_flit[a][src_pos[a]]];
        agent_cred[a]    = agent_cred[a] - 1'b1;
        src_pos[a]++;
      end
      else
      begin
        agent_put[a] = 1'b0;
        agent_eom[a] = 1'b0;
      end
    end
  end

  // Credits go back 0 to 3 cycles apart
  always @(negedge side_clk)
  begin
    for (int d = 0; d < NUM_AGENTS; d++)
    begin
      if (out_put[d] === 1'b1)
        take_flit(d);
      out_credit[d] = 1'b0;
      if (started && credit_owed[d] > 0)
      begin
        if (credit_wait[d] == 0)
        begin
          out_credit[d] = 1'b1;
          credit_owed[d]--;
          credit_pulses[d]++;
          credit_wait[d] = $unsigned($random(seed)) % 4;
        end
        else
          credit_wait[d]--;
      end
      if (out_put[d] === 1'b1)
        credit_owed[d]++;
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial
  begin
    seed          = 89;
    rst_n         = 1'b0;
    agent_put     = '0;
    agent_payload = '0;
    agent_eom     = '0;
    out_credit    = '0;
    started       = 1'b0;
    loaded        = 1'b0;
    value_errs    = 0;
    other_errs    = 0;
    rx_msgs       = 0;
    num_flits     = 0;
    num_msgs      = 0;
    for (int a = 0; a < NUM_AGENTS; a++)
    begin
      rx_len[a]        = 0;
      rx_flits[a]      = 0;
      credit_owed[a]   = QUEUE_DEPTH;
      credit_wait[a]   = 0;
      credit_pulses[a] = 0;
      agent_cred[a]    = '0;
      src_pos[a]       = 0;
    end
    load_stimulus();
    loaded = 1'b1;
    if (num_msgs == 0)
    begin
      other_errs++;
      $display("no messages read from test/sbn_input.txt");
    end

    repeat (16) @(negedge side_clk);
    rst_n = 1'b1;

    // Initial credit release with nothing sent yet
    repeat (QUEUE_DEPTH + 4) @(posedge side_clk);
    for (int a = 0; a < NUM_AGENTS; a++)
      check_count(agent_cred[a], credit_cnt_t'(QUEUE_DEPTH),
                  $sformatf("agent %0d initial credits", a));
    started = 1'b1;

    wait (rx_msgs >= num_msgs);
    repeat (20) @(posedge side_clk);
    if (pending.size() != 0)
    begin
      other_errs++;
      $display("%0d messages never arrived", pending.size());
    end
    for (int a = 0; a < NUM_AGENTS; a++)
    begin
      if (rx_len[a] != 0)
      begin
        other_errs++;
        $display("agent %0d was left with a message that never ended", a);
      end
      if (src_pos[a] != src_cnt[a])
      begin
        other_errs++;
        $display("agent %0d did not send all of its flits", a);
      end
    end

    print_summary();
    if (value_errs == 0 && other_errs == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // Watchdog scaled by the number of flits
  initial
  begin
    wait (loaded === 1'b1);
    repeat (num_flits * 40 + 2000) @(posedge side_clk);
    $display("timeout waiting for messages");
    print_summary();
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
